// File: compile.f
+incdir+verif
rtl/tetris_pkg.sv
rtl/piece_if.sv
rtl/key_strobe.sv
rtl/piece_gen.sv
rtl/drop_unit.sv
rtl/shift_unit.sv
rtl/game_ctrl.sv
rtl/tetris_top.sv
verif/tetris_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing -f compile.f --top-module tetris_tb \
        -Mdir obj_dir -o tetris_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tetris_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: verif/tetris_model.svh
`ifndef TETRIS_MODEL_SVH
`define TETRIS_MODEL_SVH

// Reference copy of the game, stepped once per rising edge
game_state_t m_state;
board_t      m_active;   // Falling piece
board_t      m_stack;    // Settled cells
piece_t      m_type;     // Shape that enters at the next spawn
logic [2:0]  left_hist;  // Key samples, newest in bit 0
logic [2:0]  right_hist;

// Moves each occupied cell by (dr, dc), off flags a cell leaving the board
function automatic board_t move_cells(input board_t b, input int dr, input int dc,
                                      output logic off);
    board_t o;
    int     nr;
    int     nc;
    o   = '0;
    off = 1'b0;
    for (int r = 0; r < ROWS; r++) begin
        for (int c = 0; c < COLS; c++) begin
            if (b[r][c]) begin
                nr = r + dr;
                nc = c + dc;
                if (nr < 0 || nr >= ROWS || nc < 0 || nc >= COLS)
                    off = 1'b1; // Would fall off or pass a wall
                else
                    o[nr][nc] = 1'b1;
            end
        end
    end
    return o;
endfunction

task automatic model_reset();
    m_state    = SPAWN;
    m_active   = '0;
    m_stack    = '0;
    m_type     = PIECE_I;
    left_hist  = '0;
    right_hist = '0;
endtask

// Next state from the inputs held during the cycle that just ended
task automatic model_step(input logic tk, input logic lk, input logic rk, input logic ng);
    logic   lp;
    logic   rp;
    logic   off;
    board_t moved;
    lp = left_hist[1] & ~left_hist[2]; // Second sample new, third still old
    rp = right_hist[1] & ~right_hist[2];
    case (m_state)
        SPAWN: begin
            moved = spawn_shape(m_type);
            if ((moved & m_stack) != '0) begin
                m_state = GAMEOVER;
            end else begin
                m_active = moved;
                m_state  = FALLING;
            end
            m_type = (m_type == PIECE_Z) ? PIECE_I : piece_t'(m_type + 3'd1);
        end
        FALLING: begin
            if (tk) begin
                moved = move_cells(m_active, 1, 0, off);
                if (off || (moved & m_stack) != '0)
                    m_state = LANDED;
                else
                    m_active = moved;
            end else if (lp != rp) begin // Exactly one direction
                moved = move_cells(m_active, 0, lp ? -1 : 1, off);
                if (!off && (moved & m_stack) == '0)
                    m_active = moved;
            end
        end
        LANDED: begin
            m_stack  = m_stack | m_active;
            m_active = '0;
            m_state  = SPAWN;
        end
        GAMEOVER: begin
            if (ng) begin
                m_stack = '0;
                m_state = SPAWN;
            end
        end
        default: m_state = SPAWN;
    endcase
    left_hist  = {left_hist[1:0], lk};
    right_hist = {right_hist[1:0], rk};
endtask

`endif

// File: verif/tetris_tb.sv
`timescale 1ns/1ps

module tetris_tb;
    import tetris_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;   // Input change after the rising edge
    localparam int RESET_CYCLES = 16;
    localparam int NUM_CYCLES   = 4000;
    localparam int BW           = ROWS * COLS;

    logic                         clk = 1'b0;
    logic                         reset;
    logic                         tick;
    logic                         left_key;
    logic                         right_key;
    logic                         new_game;
    logic [0:ROWS-1][0:COLS-1]    display;
    logic [2:0]                   piece_type;
    logic                         spawn;
    logic                         landed;
    logic                         game_over;
    int                           over_wait; // Cycles spent in game over

    `include "tetris_model.svh"

    always #(CLK_PERIOD / 2) clk = ~clk;

    tetris_top dut (
        .clk        (clk),
        .reset      (reset),
        .tick       (tick),
        .left_key   (left_key),
        .right_key  (right_key),
        .new_game   (new_game),
        .display    (display),
        .piece_type (piece_type),
        .spawn      (spawn),
        .landed     (landed),
        .game_over  (game_over)
    );

    task automatic check(input string name, input logic [BW-1:0] got, input logic [BW-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Outputs against the model, all of them decode registers only
    task automatic compare_outputs();
        board_t exp_disp;
        if (m_state == FALLING || m_state == LANDED)
            exp_disp = m_stack | m_active;
        else
            exp_disp = m_stack; // No piece on the board
        check("display", display, exp_disp);
        check("piece_type", BW'(piece_type), BW'(m_type));
        check("spawn", BW'(spawn), BW'(m_state == SPAWN));
        check("landed", BW'(landed), BW'(m_state == LANDED));
        check("game_over", BW'(game_over), BW'(m_state == GAMEOVER));
    endtask

    task automatic drive_random();
        tick = ($urandom % 4) == 0;
        if (($urandom % 6) == 0)
            left_key = ~left_key;  // Slow random key levels
        if (($urandom % 6) == 0)
            right_key = ~right_key;
        if (m_state == GAMEOVER)
            over_wait++;
        else
            over_wait = 0;
        new_game = (over_wait == 4); // Restart a few cycles into game over
    endtask

    initial begin
        void'($urandom(32'h923f));
        reset     = 1'b1;
        tick      = 1'b0;
        left_key  = 1'b0;
        right_key = 1'b0;
        new_game  = 1'b0;
        over_wait = 0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY) reset = 1'b0;
        @(negedge clk);
        compare_outputs(); // Reset values, first spawn of I
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(posedge clk);
            model_step(tick, left_key, right_key, new_game);
            #(DRIVE_DELAY);
            drive_random();
            @(negedge clk);
            compare_outputs();
        end
        $display("TEST PASS");
        $finish;
    end

    // Whole run plus some margin
    initial begin
        #((RESET_CYCLES + NUM_CYCLES + 200) * CLK_PERIOD);
        $display("Run timed out before all cycles were checked");
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: rtl/tetris_top.sv
`timescale 1ns/1ps

module tetris_top (
    input  logic                                             clk,
    input  logic                                             reset,
    input  logic                                             tick,
    input  logic                                             left_key,
    input  logic                                             right_key,
    input  logic                                             new_game,
    output logic [0:tetris_pkg::ROWS-1][0:tetris_pkg::COLS-1] display,
    output logic [2:0]                                       piece_type,
    output logic                                             spawn,
    output logic                                             landed,
    output logic                                             game_over
);
    import tetris_pkg::*;

    logic   left_pulse;  // Synchronized key strobes
    logic   right_pulse;
    board_t spawn_mask;  // Next shape from the generator

    piece_if drop_bus ();
    piece_if shift_bus ();

    key_strobe left_sync (
        .clk   (clk),
        .reset (reset),
        .key   (left_key),
        .pulse (left_pulse)
    );

    key_strobe right_sync (
        .clk   (clk),
        .reset (reset),
        .key   (right_key),
        .pulse (right_pulse)
    );

    piece_gen gen (
        .clk        (clk),
        .reset      (reset),
        .spawn      (spawn),
        .piece_type (piece_type),
        .spawn_mask (spawn_mask)
    );

    drop_unit drop (
        .bus (drop_bus.mover)
    );

    shift_unit shift (
        .left_pulse  (left_pulse),
        .right_pulse (right_pulse),
        .bus         (shift_bus.mover)
    );

    game_ctrl ctrl (
        .clk        (clk),
        .reset      (reset),
        .tick       (tick),
        .new_game   (new_game),
        .spawn_mask (spawn_mask),
        .drop_bus   (drop_bus.ctrl),
        .shift_bus  (shift_bus.ctrl),
        .display    (display),
        .spawn      (spawn),
        .landed     (landed),
        .game_over  (game_over)
    );

endmodule

// File: rtl/game_ctrl.sv
`timescale 1ns/1ps

module game_ctrl (
    input  logic               clk,
    input  logic               reset,
    input  logic               tick,      // Drop rate strobe
    input  logic               new_game,
    input  tetris_pkg::board_t spawn_mask, // Shape of the piece to enter
    piece_if.ctrl              drop_bus,
    piece_if.ctrl              shift_bus,
    output tetris_pkg::board_t display,
    output logic               spawn,
    output logic               landed,
    output logic               game_over
);
    import tetris_pkg::*;

    game_state_t state, state_next;
    board_t      active, active_next; // Falling piece
    board_t      stack, stack_next;   // Settled cells
    logic        spawn_hit;           // New piece lands on the stack

    // Both movers see the same piece and stack
    assign drop_bus.active  = active;
    assign drop_bus.stack   = stack;
    assign shift_bus.active = active;
    assign shift_bus.stack  = stack;

    assign spawn_hit = |(spawn_mask & stack);

    always_comb begin
        state_next  = state;
        active_next = active;
        stack_next  = stack;
        case (state)
            SPAWN: begin
                if (spawn_hit) begin
                    state_next = GAMEOVER; // Active stays clear
                end else begin
                    active_next = spawn_mask;
                    state_next  = FALLING;
                end
            end
            FALLING: begin
                if (tick) begin
                    // Drop wins, any shift this cycle is lost
                    if (drop_bus.blocked)
                        state_next = LANDED;
                    else
                        active_next = drop_bus.candidate;
                end else if (!shift_bus.blocked) begin
                    active_next = shift_bus.candidate;
                end
            end
            LANDED: begin
                stack_next  = stack | active; // Merge piece
                active_next = '0;
                state_next  = SPAWN;
            end
            GAMEOVER: begin
                if (new_game) begin
                    stack_next = '0; // Fresh board
                    state_next = SPAWN;
                end
            end
            default: state_next = SPAWN;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= SPAWN;
            active <= '0;
            stack  <= '0;
        end else begin
            state  <= state_next;
            active <= active_next;
            stack  <= stack_next;
        end
    end

    // Piece only visible while it is on the board
    always_comb begin
        case (state)
            FALLING, LANDED: display = stack | active;
            default:         display = stack;
        endcase
    end

    // State decodes
    assign spawn     = (state == SPAWN);    // Piece type steps after this cycle
    assign landed    = (state == LANDED);   // One cycle per landing
    assign game_over = (state == GAMEOVER); // Level until new_game

endmodule

// File: rtl/shift_unit.sv
`timescale 1ns/1ps

module shift_unit (
    input  logic   left_pulse,
    input  logic   right_pulse,
    piece_if.mover bus
);
    import tetris_pkg::*;

    typedef enum logic [1:0] {
        DIR_NONE,
        DIR_LEFT,
        DIR_RIGHT
    } shift_dir_t;

    shift_dir_t dir;
    board_t     moved;
    logic       wall;    // Piece already touches the chosen edge
    logic       overlap;

    // Both or neither pulse means no move
    always_comb begin
        case ({left_pulse, right_pulse})
            2'b10:   dir = DIR_LEFT;
            2'b01:   dir = DIR_RIGHT;
            default: dir = DIR_NONE;
        endcase
    end

    always_comb begin
        moved = bus.active;
        wall  = 1'b0;
        for (int r = 0; r < ROWS; r++) begin
            case (dir)
                DIR_LEFT: begin
                    moved[r] = bus.active[r] << 1; // Toward column 0
                    wall     = wall | bus.active[r][0];
                end
                DIR_RIGHT: begin
                    moved[r] = bus.active[r] >> 1;
                    wall     = wall | bus.active[r][COLS-1];
                end
                default: moved[r] = bus.active[r];
            endcase
        end
    end

    assign overlap = |(moved & bus.stack);

    assign bus.candidate = moved;
    assign bus.blocked   = (dir == DIR_NONE) | wall | overlap;

endmodule

// File: rtl/drop_unit.sv
`timescale 1ns/1ps

module drop_unit (
    piece_if.mover bus
);
    import tetris_pkg::*;

    board_t moved;   // Piece one row lower
    logic   floor;   // Piece rests on the bottom row
    logic   overlap; // Moved piece hits the stack

    always_comb begin
        moved[0] = '0; // Nothing enters from above
        for (int r = 1; r < ROWS; r++) begin
            moved[r] = bus.active[r-1];
        end
    end

    // Bottom row would fall off the board
    assign floor = |bus.active[ROWS-1];

    // Any shared cell with the settled cells
    assign overlap = |(moved & bus.stack);

    assign bus.candidate = moved;
    assign bus.blocked   = floor | overlap;

endmodule

// File: rtl/piece_gen.sv
`timescale 1ns/1ps

module piece_gen (
    input  logic                clk,
    input  logic                reset,
    input  logic                spawn,      // Advance after this cycle
    output tetris_pkg::piece_t  piece_type,
    output tetris_pkg::board_t  spawn_mask
);
    import tetris_pkg::*;

    piece_t type_q; // Shape of the next piece to enter
    piece_t type_next;

    // Fixed issue order, wraps after Z
    always_comb begin
        type_next = type_q;
        if (spawn) begin
            if (type_q == PIECE_Z)
                type_next = PIECE_I;
            else
                type_next = piece_t'(type_q + 3'd1);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            type_q <= PIECE_I; // First piece is always I
        else
            type_q <= type_next;
    end

    assign piece_type = type_q;

    // Shape table lookup
    assign spawn_mask = spawn_shape(type_q);

endmodule

// File: rtl/key_strobe.sv
`timescale 1ns/1ps

module key_strobe (
    input  logic clk,
    input  logic reset,
    input  logic key,   // Raw asynchronous key level
    output logic pulse  // One cycle per press
);

    logic sync_1; // First stage, may go metastable
    logic sync_2; // Synchronized level
    logic sync_d; // Previous synchronized level

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_1 <= 1'b0;
            sync_2 <= 1'b0;
            sync_d <= 1'b0;
        end else begin
            sync_1 <= key;
            sync_2 <= sync_1;
            sync_d <= sync_2;
        end
    end

    // Rising edge of the synchronized level
    // Held key stays high in both stages so no repeat
    assign pulse = sync_2 & ~sync_d;

endmodule

// File: rtl/piece_if.sv
`timescale 1ns/1ps

interface piece_if;
    import tetris_pkg::*;

    board_t active;    // Current falling piece
    board_t stack;     // Settled cells
    board_t candidate; // Proposed next position
    logic   blocked;   // Proposal not allowed

    // Controller side
    modport ctrl (
        output active,
        output stack,
        input  candidate,
        input  blocked
    );

    // Drop or shift side
    modport mover (
        input  active,
        input  stack,
        output candidate,
        output blocked
    );

endinterface

// File: rtl/tetris_pkg.sv
package tetris_pkg;

    // Board geometry
    localparam int ROWS = 20; // Row 0 at the top
    localparam int COLS = 10; // Column 0 at the left

    // Column 0 sits in the MSB of a row
    typedef logic [0:COLS-1] row_t;

    // Row 0 is the most significant row of the board
    typedef row_t [0:ROWS-1] board_t;

    // Shapes in issue order
    typedef enum logic [2:0] {
        PIECE_I,
        PIECE_O,
        PIECE_T,
        PIECE_L,
        PIECE_J,
        PIECE_S,
        PIECE_Z
    } piece_t;

    // Controller states
    typedef enum logic [1:0] {
        SPAWN,
        FALLING,
        LANDED,
        GAMEOVER
    } game_state_t;

    // Spawn position of each shape, rows 0 and 1 only
    function automatic board_t spawn_shape(piece_t p);
        board_t b;
        b = '0;
        case (p)
            PIECE_I: b[0][3:6] = 4'b1111;
            PIECE_O: begin
                b[0][4:5] = 2'b11;
                b[1][4:5] = 2'b11;
            end
            PIECE_T: begin
                b[0][3:5] = 3'b111;
                b[1][4]   = 1'b1; // Stem under the middle
            end
            PIECE_L: begin
                b[0][3:5] = 3'b111;
                b[1][3]   = 1'b1;
            end
            PIECE_J: begin
                b[0][3:5] = 3'b111;
                b[1][5]   = 1'b1;
            end
            PIECE_S: begin
                b[0][4:5] = 2'b11;
                b[1][3:4] = 2'b11;
            end
            PIECE_Z: begin
                b[0][3:4] = 2'b11;
                b[1][4:5] = 2'b11;
            end
            default: b = '0;
        endcase
        return b;
    endfunction

endpackage
